//--- Makefile
TOP  := tb_panel
SRCS := $(filter %.sv,$(shell cat src.f)) panel_config.svh

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): $(SRCS) src.f
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^Regression passed$$" sim.log

lint:
	verilator --lint-only -f src.f --top-module panel_top

clean:
	rm -rf obj_dir sim.log

//--- block_ram.sv
`timescale 1ns/1ps

module block_ram #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                clk,
    input  panel_pkg::mem_req_t req,
    output panel_pkg::word_t    rdata
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    panel_pkg::word_t mem [DEPTH];

    logic [ADDR_WIDTH-1:0] index;

    assign index = req.addr[ADDR_WIDTH-1:0];   // Upper address bits ignored

    // Contents start cleared
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (req.we) begin
            mem[index] <= req.wdata;
        end
        rdata <= mem[index];                    // Read first, every cycle
    end

endmodule

//--- button_debouncer.sv
`timescale 1ns/1ps
`include "panel_config.svh"

module button_debouncer (
    input  logic clk,
    input  logic reset,
    input  logic btn,
    output logic press,
    output logic short_release,
    output logic long_hold
);

    localparam int DB_W   = $clog2(`PANEL_DEBOUNCE_CYCLES + 1);
    localparam int HOLD_W = $clog2(`PANEL_LONG_CYCLES + 1);

    logic [1:0]        btn_sync;    // Raw input is asynchronous
    logic [DB_W-1:0]   db_cnt;
    logic              level;       // Debounced level
    logic              level_d;
    logic [HOLD_W-1:0] hold_cnt;
    logic              long_fired;  // Long strobe already given this press

    always_ff @(posedge clk) begin
        if (reset) begin
            btn_sync      <= '0;
            db_cnt        <= '0;
            level         <= 1'b0;
            level_d       <= 1'b0;
            hold_cnt      <= '0;
            long_fired    <= 1'b0;
            press         <= 1'b0;
            short_release <= 1'b0;
            long_hold     <= 1'b0;
        end else begin
            btn_sync <= {btn_sync[0], btn};
            level_d  <= level;

            // Accept a new level only once it has held long enough
            if (btn_sync[1] == level) begin
                db_cnt <= '0;
            end else if (db_cnt == DB_W'(`PANEL_DEBOUNCE_CYCLES - 1)) begin
                db_cnt <= '0;
                level  <= btn_sync[1];
            end else begin
                db_cnt <= db_cnt + 1'b1;
            end

            press         <= level & ~level_d;                  // Rising edge
            short_release <= ~level & level_d & ~long_fired;    // Fall, no long seen
            long_hold     <= 1'b0;

            if (!level) begin
                hold_cnt   <= '0;
                long_fired <= 1'b0;
            end else if (!long_fired) begin
                if (hold_cnt == HOLD_W'(`PANEL_LONG_CYCLES - 1)) begin
                    long_hold  <= 1'b1;                         // Once per press
                    long_fired <= 1'b1;
                end else begin
                    hold_cnt <= hold_cnt + 1'b1;
                end
            end
        end
    end

endmodule

//--- front_panel.sv
`timescale 1ns/1ps

module front_panel (
    input  logic                clk,
    input  logic                reset,
    input  panel_pkg::word_t    sw,
    input  logic                l_short,
    input  logic                l_long,
    input  logic                u_press,
    input  logic                d_press,
    input  panel_pkg::word_t    imem_rdata,
    input  panel_pkg::word_t    dmem_rdata,
    input  panel_pkg::word_t    io_rdata,
    input  panel_pkg::word_t    io_leds,
    output panel_pkg::mem_req_t imem_req,
    output panel_pkg::mem_req_t dmem_req,
    output panel_pkg::io_req_t  io_req,
    output panel_pkg::word_t    led,
    output panel_pkg::disp_t    disp
);

    panel_pkg::mode_t        mode;
    panel_pkg::panel_state_t state;
    panel_pkg::word_t        address;       // Current examine/deposit address
    panel_pkg::word_t        data_shown;    // Last word read or written
    logic                    mem_sel;       // 1 selects instruction memory

    logic in_panel;
    logic tgt_imem;
    logic tgt_dmem;
    logic tgt_io;

    assign in_panel = (mode == panel_pkg::MODE_PANEL);
    assign tgt_imem = in_panel && mem_sel;
    assign tgt_dmem = in_panel && !mem_sel && !address[15];
    assign tgt_io   = in_panel && !mem_sel && address[15];

    // Short L enters, long L leaves
    always_ff @(posedge clk) begin
        if (reset) begin
            mode <= panel_pkg::MODE_NORMAL;
        end else if (!in_panel && l_short) begin
            mode <= panel_pkg::MODE_PANEL;
        end else if (in_panel && l_long) begin
            mode <= panel_pkg::MODE_NORMAL;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= panel_pkg::ST_IDLE;
            address    <= '0;
            data_shown <= '0;
            mem_sel    <= 1'b0;
        end else if (!in_panel) begin
            if (l_short) begin
                mem_sel <= 1'b0;                        // Always enter on data side
                state   <= panel_pkg::ST_IDLE;
            end
        end else begin
            case (state)
                panel_pkg::ST_IDLE: begin
                    if (u_press) begin
                        address <= sw;                  // Examine
                        state   <= panel_pkg::ST_READ_WAIT;
                    end else if (d_press) begin
                        state <= panel_pkg::ST_WRITE;   // Deposit
                    end else if (l_short) begin
                        mem_sel <= ~mem_sel;
                    end
                end
                panel_pkg::ST_READ_WAIT: begin
                    // Instruction side gets one more cycle
                    state <= mem_sel ? panel_pkg::ST_READ_WAIT2 : panel_pkg::ST_READ_DONE;
                end
                panel_pkg::ST_READ_WAIT2: begin
                    state <= panel_pkg::ST_READ_DONE;
                end
                panel_pkg::ST_READ_DONE: begin
                    if (mem_sel) begin
                        data_shown <= imem_rdata;
                    end else if (!address[15]) begin
                        data_shown <= dmem_rdata;
                    end else begin
                        data_shown <= io_rdata;
                    end
                    state <= panel_pkg::ST_IDLE;
                end
                panel_pkg::ST_WRITE: begin
                    data_shown <= sw;                   // Echo written word
                    state      <= panel_pkg::ST_WRITE_DONE;
                end
                panel_pkg::ST_WRITE_DONE: begin
                    address <= address + 16'd1;         // Ready for next deposit
                    state   <= panel_pkg::ST_IDLE;
                end
                default: begin
                    state <= panel_pkg::ST_IDLE;
                end
            endcase
        end
    end

    // Only the selected target sees the address and strobes
    always_comb begin
        imem_req = '0;
        dmem_req = '0;
        io_req   = '0;
        if (tgt_imem) begin
            imem_req.addr  = address;
            imem_req.wdata = sw;
            imem_req.we    = (state == panel_pkg::ST_WRITE);
        end
        if (tgt_dmem) begin
            dmem_req.addr  = address;
            dmem_req.wdata = sw;
            dmem_req.we    = (state == panel_pkg::ST_WRITE);
        end
        if (tgt_io) begin
            io_req.addr  = address;
            io_req.wdata = sw;
            io_req.rd    = (state == panel_pkg::ST_READ_WAIT);     // Single cycle
            io_req.wr    = (state == panel_pkg::ST_WRITE);
        end
    end

    always_comb begin
        if (in_panel) begin
            led        = data_shown;
            disp.value = address;
            disp.dp    = {mem_sel, ~mem_sel, 2'b00};    // Which memory is selected
        end else begin
            led        = io_leds;
            disp.value = io_leds;
            disp.dp    = 4'b0000;
        end
    end

endmodule

//--- io_regs.sv
`timescale 1ns/1ps
`include "panel_config.svh"

module io_regs (
    input  logic               clk,
    input  logic               reset,
    input  panel_pkg::io_req_t req,
    input  panel_pkg::word_t   sw,
    output panel_pkg::word_t   rdata,
    output panel_pkg::word_t   leds
);

    logic led_hit;

    assign led_hit = (req.addr == `PANEL_IO_LED_ADDR);

    // LED register, other write addresses dropped
    always_ff @(posedge clk) begin
        if (reset) begin
            leds <= '0;
        end else if (req.wr && led_hit) begin
            leds <= req.wdata;
        end
    end

    // Read data lands one cycle after the strobe
    always_ff @(posedge clk) begin
        if (req.rd) begin
            case (req.addr)
                `PANEL_IO_LED_ADDR: begin
                    rdata <= leds;
                end
                `PANEL_IO_SW_ADDR: begin
                    rdata <= sw;                // Live switch value
                end
                default: begin
                    rdata <= '0;                // Unmapped
                end
            endcase
        end
    end

endmodule

//--- panel_config.svh
`ifndef PANEL_CONFIG_SVH
`define PANEL_CONFIG_SVH

// Button timing in clk cycles, kept short for simulation
`define PANEL_DEBOUNCE_CYCLES 16
`define PANEL_LONG_CYCLES     200

// Cycles each display digit stays lit
`define PANEL_SCAN_CYCLES     8

// Memory address widths in words
`define PANEL_IMEM_AW         14
`define PANEL_DMEM_AW         15

// I/O space starts where address bit 15 is set
`define PANEL_IO_LED_ADDR     16'h8000
`define PANEL_IO_SW_ADDR      16'h8001

`endif

//--- panel_pkg.sv
package panel_pkg;

    typedef logic [15:0] word_t;    // Data and address word

    typedef enum logic {
        MODE_NORMAL,                // LED register on led and display
        MODE_PANEL                  // Examine/deposit by hand
    } mode_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_READ_WAIT,
        ST_READ_WAIT2,              // Extra slot for instruction memory
        ST_READ_DONE,
        ST_WRITE,
        ST_WRITE_DONE
    } panel_state_t;

    // Request to either RAM, read data comes back every cycle
    typedef struct packed {
        logic  we;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    // Request to the I/O register space
    typedef struct packed {
        logic  rd;
        logic  wr;
        word_t addr;
        word_t wdata;
    } io_req_t;

    typedef struct packed {
        word_t      value;          // Four hex digits
        logic [3:0] dp;             // Bit 3 is the leftmost digit
    } disp_t;

endpackage

//--- panel_top.sv
`timescale 1ns/1ps
`include "panel_config.svh"

module panel_top (
    input  logic             clk,
    input  logic             reset,
    input  panel_pkg::word_t sw,
    input  logic             btn_l,     // Mode and memory select
    input  logic             btn_u,     // Examine
    input  logic             btn_d,     // Deposit
    output panel_pkg::word_t led,
    output logic [3:0]       an,
    output logic [6:0]       seg,
    output logic             dp
);

    logic l_short;
    logic l_long;
    logic u_press;
    logic d_press;

    panel_pkg::mem_req_t imem_req;
    panel_pkg::mem_req_t dmem_req;
    panel_pkg::io_req_t  io_req;
    panel_pkg::word_t    imem_rdata;
    panel_pkg::word_t    dmem_rdata;
    panel_pkg::word_t    io_rdata;
    panel_pkg::word_t    io_leds;
    panel_pkg::disp_t    disp;

    button_debouncer u_deb_l (
        .clk           (clk),
        .reset         (reset),
        .btn           (btn_l),
        .press         (),
        .short_release (l_short),
        .long_hold     (l_long)
    );

    button_debouncer u_deb_u (
        .clk           (clk),
        .reset         (reset),
        .btn           (btn_u),
        .press         (u_press),
        .short_release (),
        .long_hold     ()
    );

    button_debouncer u_deb_d (
        .clk           (clk),
        .reset         (reset),
        .btn           (btn_d),
        .press         (d_press),
        .short_release (),
        .long_hold     ()
    );

    front_panel u_front_panel (
        .clk        (clk),
        .reset      (reset),
        .sw         (sw),
        .l_short    (l_short),
        .l_long     (l_long),
        .u_press    (u_press),
        .d_press    (d_press),
        .imem_rdata (imem_rdata),
        .dmem_rdata (dmem_rdata),
        .io_rdata   (io_rdata),
        .io_leds    (io_leds),
        .imem_req   (imem_req),
        .dmem_req   (dmem_req),
        .io_req     (io_req),
        .led        (led),
        .disp       (disp)
    );

    block_ram #(.ADDR_WIDTH(`PANEL_IMEM_AW)) u_imem (
        .clk   (clk),
        .req   (imem_req),
        .rdata (imem_rdata)
    );

    block_ram #(.ADDR_WIDTH(`PANEL_DMEM_AW)) u_dmem (
        .clk   (clk),
        .req   (dmem_req),
        .rdata (dmem_rdata)
    );

    io_regs u_io_regs (
        .clk   (clk),
        .reset (reset),
        .req   (io_req),
        .sw    (sw),
        .rdata (io_rdata),
        .leds  (io_leds)
    );

    sevenseg_driver u_sevenseg (
        .clk   (clk),
        .reset (reset),
        .disp  (disp),
        .an    (an),
        .seg   (seg),
        .dp    (dp)
    );

endmodule

//--- sevenseg_driver.sv
`timescale 1ns/1ps
`include "panel_config.svh"

module sevenseg_driver (
    input  logic             clk,
    input  logic             reset,
    input  panel_pkg::disp_t disp,
    output logic [3:0]       an,
    output logic [6:0]       seg,
    output logic             dp
);

    localparam int SCAN_W = $clog2(`PANEL_SCAN_CYCLES + 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [1:0]        digit;       // 0 is the rightmost digit
    logic [3:0]        nibble;

    always_ff @(posedge clk) begin
        if (reset) begin
            scan_cnt <= '0;
            digit    <= 2'd0;
        end else if (scan_cnt == SCAN_W'(`PANEL_SCAN_CYCLES - 1)) begin
            scan_cnt <= '0;
            digit    <= digit + 2'd1;   // Wraps after digit 3
        end else begin
            scan_cnt <= scan_cnt + 1'b1;
        end
    end

    assign an     = ~(4'b0001 << digit);          // One-hot, active low
    assign nibble = disp.value[digit*4 +: 4];
    assign dp     = ~disp.dp[digit];

    // Segments ordered gfedcba, active low
    always_comb begin
        case (nibble)
            4'h0: seg = 7'b1000000;
            4'h1: seg = 7'b1111001;
            4'h2: seg = 7'b0100100;
            4'h3: seg = 7'b0110000;
            4'h4: seg = 7'b0011001;
            4'h5: seg = 7'b0010010;
            4'h6: seg = 7'b0000010;
            4'h7: seg = 7'b1111000;
            4'h8: seg = 7'b0000000;
            4'h9: seg = 7'b0010000;
            4'hA: seg = 7'b0001000;
            4'hB: seg = 7'b0000011;     // Lower case b
            4'hC: seg = 7'b1000110;
            4'hD: seg = 7'b0100001;     // Lower case d
            4'hE: seg = 7'b0000110;
            default: seg = 7'b0001110;  // F
        endcase
    end

endmodule

//--- src.f
+incdir+.
panel_pkg.sv
button_debouncer.sv
front_panel.sv
block_ram.sv
io_regs.sv
sevenseg_driver.sv
panel_top.sv
tb_panel.sv

//--- tb_panel.sv
`timescale 1ns/1ps
`include "panel_config.svh"

module tb_panel;

    localparam int SEED        = 36389;
    localparam int NUM_WORDS   = 4;                          // Deposits per memory run
    localparam int SHORT_HOLD  = 40;                         // Well under the long threshold
    localparam int LONG_HOLD   = `PANEL_LONG_CYCLES + 60;
    localparam int GAP         = 40;                         // Release debounce plus slack
    localparam int SCAN_ROUND  = 4 * `PANEL_SCAN_CYCLES + 4; // Every digit seen once
    localparam int NUM_PRESSES = 3 * NUM_WORDS + 11;
    localparam int WATCHDOG_CYCLES = NUM_PRESSES * (LONG_HOLD + GAP + SCAN_ROUND) + 500;
    localparam int BTN_L = 0;
    localparam int BTN_U = 1;
    localparam int BTN_D = 2;

    // Lit segments gfedcba per hex digit, active high
    localparam logic [6:0] SEG_ON [16] = '{
        7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
        7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71
    };

    logic             clk = 1'b0;
    logic             reset;
    panel_pkg::word_t sw;
    logic             btn_l;
    logic             btn_u;
    logic             btn_d;
    panel_pkg::word_t led;
    logic [3:0]       an;
    logic [6:0]       seg;
    logic             dp;

    // Reference model state
    logic [15:0]      dmem_model [2**`PANEL_DMEM_AW];
    logic [15:0]      imem_model [2**`PANEL_IMEM_AW];
    panel_pkg::word_t exp_led_reg;
    panel_pkg::word_t exp_addr;
    panel_pkg::word_t exp_shown;    // Word the panel should show on led
    logic             exp_panel;
    logic             exp_sel;      // 1 for instruction memory
    panel_pkg::word_t exp_led;
    panel_pkg::word_t exp_value;
    logic [3:0]       exp_dp;
    logic [1:0]       scan_digit;
    logic [3:0]       exp_nibble;
    logic [6:0]       exp_seg;
    logic             exp_dp_pin;

    logic             check_on;     // Low while a button is in flight
    string            test_name;
    logic [31:0]      rng;

    panel_top u_panel_top (
        .clk   (clk),
        .reset (reset),
        .sw    (sw),
        .btn_l (btn_l),
        .btn_u (btn_u),
        .btn_d (btn_d),
        .led   (led),
        .an    (an),
        .seg   (seg),
        .dp    (dp)
    );

    always #20 clk = ~clk;          // 40 ns period

    // Expected outputs from the mode and the model
    always_comb begin
        exp_led   = exp_panel ? exp_shown : exp_led_reg;
        exp_value = exp_panel ? exp_addr : exp_led_reg;
        exp_dp    = exp_panel ? {exp_sel, ~exp_sel, 2'b00} : 4'b0000;
        case (an)
            4'b1101: scan_digit = 2'd1;
            4'b1011: scan_digit = 2'd2;
            4'b0111: scan_digit = 2'd3;
            default: scan_digit = 2'd0;
        endcase
        exp_nibble = 4'(exp_value >> (4 * scan_digit));
        exp_seg    = ~SEG_ON[exp_nibble];                   // Pins are active low
        exp_dp_pin = ~exp_dp[scan_digit];
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_led(input panel_pkg::word_t expected);
        assert (led == expected)
            else stop_on_error($sformatf("Mismatch in %s: expected %h, actual %h",
                                         test_name, expected, led));
    endtask

    // Hold one button, release, then wait out the release debounce
    task automatic push(input int which, input int hold);
        check_on = 1'b0;
        btn_l    = (which == BTN_L);
        btn_u    = (which == BTN_U);
        btn_d    = (which == BTN_D);
        repeat (hold) @(posedge clk);
        #2;
        btn_l = 1'b0;
        btn_u = 1'b0;
        btn_d = 1'b0;
        repeat (GAP) @(posedge clk);
        #2;
    endtask

    // One full scan, every digit must light
    task automatic watch_display();
        logic [3:0] lit;            // Digits seen lit so far
        lit      = 4'b0000;
        check_on = 1'b1;
        repeat (SCAN_ROUND) begin
            @(negedge clk);
            lit = lit | ~an;
            @(posedge clk);
        end
        #2;
        assert (lit == 4'b1111)
            else stop_on_error($sformatf("Display in %s never lit digits %b",
                                         test_name, ~lit));
    endtask

    task automatic examine(input panel_pkg::word_t addr, input panel_pkg::word_t expected);
        sw = addr;                  // Address comes from the switches
        push(BTN_U, SHORT_HOLD);
        exp_addr  = addr;
        exp_shown = expected;
        check_led(expected);
        watch_display();
    endtask

    task automatic deposit(input panel_pkg::word_t data);
        sw = data;
        push(BTN_D, SHORT_HOLD);
        if (exp_sel) begin
            imem_model[exp_addr[`PANEL_IMEM_AW-1:0]] = data;
        end else if (!exp_addr[15]) begin
            dmem_model[exp_addr[`PANEL_DMEM_AW-1:0]] = data;
        end else if (exp_addr == `PANEL_IO_LED_ADDR) begin
            exp_led_reg = data;
        end
        exp_shown = data;           // Written word echoed on led
        exp_addr  = exp_addr + 16'd1;
        check_led(data);
        watch_display();
    endtask

    task automatic toggle_select();
        push(BTN_L, SHORT_HOLD);
        exp_sel = ~exp_sel;
        watch_display();
    endtask

    anode_onehot: assert property (@(negedge clk) disable iff (reset || !check_on)
        $onehot(~an))
        else stop_on_error($sformatf("Anodes %b in %s do not light exactly one digit",
                                     an, test_name));

    led_value: assert property (@(negedge clk) disable iff (reset || !check_on)
        led == exp_led)
        else stop_on_error($sformatf("Mismatch in %s: expected %h, actual %h",
                                     test_name, exp_led, led));

    seg_value: assert property (@(negedge clk) disable iff (reset || !check_on)
        seg == exp_seg)
        else stop_on_error($sformatf("Mismatch in %s: expected %b, actual %b",
                                     test_name, exp_seg, seg));

    dp_value: assert property (@(negedge clk) disable iff (reset || !check_on)
        dp == exp_dp_pin)
        else stop_on_error($sformatf("Mismatch in %s: expected %b, actual %b",
                                     test_name, exp_dp_pin, dp));

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        stop_on_error("Watchdog expired before the tests finished");
    end

    initial begin
        panel_pkg::word_t base;
        panel_pkg::word_t addr;
        reset       = 1'b1;
        sw          = '0;
        btn_l       = 1'b0;
        btn_u       = 1'b0;
        btn_d       = 1'b0;
        check_on    = 1'b0;
        rng         = SEED;
        test_name   = "reset";
        exp_panel   = 1'b0;
        exp_sel     = 1'b0;
        exp_addr    = '0;
        exp_shown   = '0;
        exp_led_reg = '0;
        for (int i = 0; i < 2**`PANEL_DMEM_AW; i++) begin
            dmem_model[i] = '0;
        end
        for (int i = 0; i < 2**`PANEL_IMEM_AW; i++) begin
            imem_model[i] = '0;
        end
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b0;
        check_led(16'h0000);
        watch_display();

        test_name = "enter panel";
        push(BTN_L, SHORT_HOLD);
        exp_panel = 1'b1;
        exp_sel   = 1'b0;           // Always enters on the data side
        watch_display();

        // Data memory run below the I/O space
        test_name = "dmem deposit";
        rng  = xorshift32(rng);
        base = rng[15:0] & 16'h7FF0;
        examine(base, dmem_model[base[`PANEL_DMEM_AW-1:0]]);
        for (int i = 0; i < NUM_WORDS; i++) begin
            rng = xorshift32(rng);
            deposit(rng[15:0]);
        end
        test_name = "dmem examine";
        for (int i = 0; i < NUM_WORDS; i++) begin
            addr = base + 16'(i);
            examine(addr, dmem_model[addr[`PANEL_DMEM_AW-1:0]]);
        end

        // Same address on the instruction side
        test_name = "imem select";
        toggle_select();
        test_name = "imem deposit";
        examine(base, imem_model[base[`PANEL_IMEM_AW-1:0]]);
        rng = xorshift32(rng);
        deposit(rng[15:0]);
        test_name = "imem examine";
        examine(base, imem_model[base[`PANEL_IMEM_AW-1:0]]);
        test_name = "dmem after imem";
        toggle_select();
        for (int i = 0; i < NUM_WORDS; i++) begin
            addr = base + 16'(i);
            examine(addr, dmem_model[addr[`PANEL_DMEM_AW-1:0]]);
        end

        test_name = "io switch readback";
        examine(`PANEL_IO_SW_ADDR, `PANEL_IO_SW_ADDR);     // sw holds the address here
        test_name = "io led deposit";
        examine(`PANEL_IO_LED_ADDR, exp_led_reg);
        rng = xorshift32(rng);
        deposit(rng[15:0]);
        test_name = "normal mode led";
        push(BTN_L, LONG_HOLD);
        exp_panel = 1'b0;
        check_led(exp_led_reg);
        watch_display();

        $display("Regression passed");
        $finish;
    end

endmodule
